// File: bench/mac_glue_testdata.txt
// op a b c d, hex. 1 word: index byte_addr word exp_sdram_addr
// 2 disk end: index final_word exp_double exp_inserted, 3 eject: bits 0 exp_double exp_inserted
// 4 cpu: addr data ctl(uds_n lds_n we_n oe_n rom_oe_n) exp_screen, 5 size: mem_size 0 0 exp_size
1 0 000010 a55a 200008
1 0 000012 1234 200009
1 1 000020 beef 280010
1 1 0a0000 c0de 2d0000
1 2 000104 0f1e 300082
2 1 064000 1 1
2 2 032000 1 3
3 1 0 0 2
2 1 000100 0 2
4 078000 1111 03 1
4 070000 2222 03 0
4 078000 3333 0b 1
4 078000 4444 05 0
4 000400 0000 06 0
5 1 0 0 2
4 078000 5555 03 0
4 0f8000 6666 03 1
5 2 0 0 3
4 1f8000 7777 03 0
4 3f8000 8888 03 1
4 3f8000 9999 07 0
5 3 0 0 0
4 018000 aaaa 03 1
4 010000 bbbb 03 0
f 0 0 0 0

// File: bench/tb_mac_mem_glue.sv
module tb_mac_mem_glue;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_BITS = 4;
  localparam int REC_MAX    = 64;
  localparam int CEN_NEEDED = (1 << RESET_BITS) - 1;

  logic        clk_sys, RESET, pll_locked_i, reset_req_i, ioctl_download_i, ioctl_wr_i;
  logic        dio_slot_i, mem_uds_n_i, mem_lds_n_i, ram_we_n_i, ram_oe_n_i, rom_oe_n_i;
  logic        ioctl_wait_o, sdram_we_o, sdram_oe_o, screen_write_o;
  logic        cep_o, cen_o, cel_o, cepix_o, sys_reset_n_o;
  logic [1:0]  mem_size_i, ram_size_o, disk_eject_i, disk_inserted_o, disk_double_o;
  logic [1:0]  sdram_ds_o;
  logic [7:0]  ioctl_index_i, ioctl_data_i;
  logic [15:0] mem_data_i, sdram_din_o;
  logic [21:0] mem_addr_i;
  logic [24:0] ioctl_addr_i, sdram_addr_o;

  // each record holds an opcode and four operands
  logic [31:0] rec_mem [0:REC_MAX*5-1];
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          cen_low_cnt = 0;
  int unsigned seed_val;

  mac_mem_glue #(.RESET_BITS(RESET_BITS)) dut0 (.*);

  initial clk_sys = 1'b0;
  always #10 clk_sys = ~clk_sys;

  // ==================================================
  // common helpers
  // ==================================================

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk_sys);
    #2;
  endtask

  always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
      abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
  end

  // cen pulses seen while the system is held in reset
  always @(negedge clk_sys) begin
    if (sys_reset_n_o)
      cen_low_cnt <= 0;
    else if (cen_o)
      cen_low_cnt <= cen_low_cnt + 1;
  end

  // ==================================================
  // stimulus tasks
  // ==================================================

  task automatic check_strobes();
    int         n_cep;
    int         n_cen;
    int         n_cel;
    int         n_pix;
    logic [7:0] cep_hist;
    n_cep = 0;
    n_cen = 0;
    n_cel = 0;
    n_pix = 0;
    cep_hist = '0;
    @(negedge clk_sys);
    check("cep_o cen_o cel_o cepix_o", {cep_o, cen_o, cel_o, cepix_o}, 4'b0000);
    repeat (32) begin
      @(negedge clk_sys);
      if (cen_o)
        check("cep_o four cycles before cen_o", cep_hist[3], 1'b1);
      n_cep += cep_o;
      n_cen += cen_o;
      n_cel += cel_o;
      n_pix += cepix_o;
      cep_hist = {cep_hist[6:0], cep_o};
    end
    check("cep_o count", n_cep, 4);
    check("cen_o count", n_cen, 4);
    check("cel_o count", n_cel, 4);
    check("cepix_o count", n_pix, 8);
  endtask

  task automatic wait_reset_release(input logic [1:0] exp_size);
    int n;
    n = 0;
    do begin
      @(negedge clk_sys);
      n++;
      if (n > (CEN_NEEDED + 4) * 8)
        abort_run("sys_reset_n_o never rose after the reset countdown");
    end while (sys_reset_n_o !== 1'b1);
    check("cen pulses before release", cen_low_cnt >= CEN_NEEDED, 1);
    check("ram_size_o", ram_size_o, exp_size);
  endtask

  task automatic write_word(input logic [7:0] index, input logic [24:0] addr,
                            input logic [15:0] word, input logic [24:0] exp_addr);
    int   tries;
    int   n;
    logic written;
    next_cycle();
    ioctl_download_i = 1'b1;
    ioctl_index_i = index;
    ioctl_wr_i = 1'b1;
    ioctl_addr_i = {addr[24:1], 1'b0};
    ioctl_data_i = word[15:8];
    next_cycle();
    ioctl_addr_i = {addr[24:1], 1'b1};
    ioctl_data_i = word[7:0];
    next_cycle();
    ioctl_wr_i = 1'b0;
    @(negedge clk_sys);
    check("ioctl_wait_o", ioctl_wait_o, 1'b1);
    written = 1'b0;
    tries = 0;
    // random gaps between two-cycle slots until the word goes out
    while (!written) begin
      if (tries == 4)
        abort_run("no sdram write seen in four slots after the odd byte");
      repeat (1 + ($urandom % 4)) next_cycle();
      repeat (2) begin
        next_cycle();
        dio_slot_i = 1'b1;
        @(negedge clk_sys);
        if (sdram_we_o) begin
          check("sdram_din_o", sdram_din_o, word);
          check("sdram_addr_o", sdram_addr_o, exp_addr);
          check("sdram_ds_o", sdram_ds_o, 2'b11);
          written = 1'b1;
        end
      end
      next_cycle();
      dio_slot_i = 1'b0;
      tries++;
    end
    n = 0;
    do begin
      @(negedge clk_sys);
      n++;
      if (n > 3)
        abort_run("ioctl_wait_o did not clear after the write slot");
    end while (ioctl_wait_o);
    next_cycle();
    ioctl_download_i = 1'b0;
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    int          r;
    int          budget;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    seed_val = $urandom(32'hf482_c784);
    RESET = 1'b1;
    pll_locked_i = 1'b1;
    reset_req_i = 1'b0;
    mem_size_i = 2'd0;
    ioctl_download_i = 1'b0;
    ioctl_index_i = '0;
    ioctl_wr_i = 1'b0;
    ioctl_addr_i = '0;
    ioctl_data_i = '0;
    dio_slot_i = 1'b0;
    disk_eject_i = '0;
    mem_addr_i = '0;
    mem_data_i = '0;
    {mem_uds_n_i, mem_lds_n_i, ram_we_n_i, ram_oe_n_i, rom_oe_n_i} = 5'h1f;
    $readmemh("bench/mac_glue_testdata.txt", rec_mem);
    if (rec_mem[0] === 32'hx)
      abort_run("could not read bench/mac_glue_testdata.txt");
    budget = 80;
    for (r = 0; r < REC_MAX && rec_mem[r*5] !== 32'hf; r++)
      budget += (rec_mem[r*5] == 1) ? 40 : (rec_mem[r*5] == 5) ? CEN_NEEDED * 8 + 16 : 8;
    cycle_limit = 2 * budget + (CEN_NEEDED + 1) * 8 + 16;

    repeat (5) next_cycle();
    RESET = 1'b0;
    check_strobes();
    wait_reset_release(2'd1);

    for (r = 0; r < REC_MAX && rec_mem[r*5] !== 32'hf; r++) begin
      op = rec_mem[r*5];
      a = rec_mem[r*5+1];
      b = rec_mem[r*5+2];
      c = rec_mem[r*5+3];
      d = rec_mem[r*5+4];
      case (op)
        1: write_word(a[7:0], b[24:0], c[15:0], d[24:0]);
        2, 3: begin
          next_cycle();
          if (op == 2) begin
            ioctl_download_i = 1'b1;
            ioctl_index_i = a[7:0];
            ioctl_addr_i = {b[23:0], 1'b0};
          end else begin
            disk_eject_i = a[1:0];
          end
          next_cycle();
          ioctl_download_i = 1'b0;
          disk_eject_i = 2'b00;
          repeat (2) next_cycle();
          @(negedge clk_sys);
          check("disk_double_o", disk_double_o, c);
          check("disk_inserted_o", disk_inserted_o, d);
        end
        4: begin
          next_cycle();
          mem_addr_i = a[21:0];
          mem_data_i = b[15:0];
          {mem_uds_n_i, mem_lds_n_i, ram_we_n_i, ram_oe_n_i, rom_oe_n_i} = c[4:0];
          @(negedge clk_sys);
          check("sdram_addr_o", sdram_addr_o, {3'b000, !c[0], a[21:1]});
          check("sdram_din_o", sdram_din_o, b[15:0]);
          check("sdram_ds_o", sdram_ds_o, {!c[4], !c[3]});
          check("sdram_we_o", sdram_we_o, !c[2]);
          check("sdram_oe_o", sdram_oe_o, !c[1] || !c[0]);
          check("screen_write_o", screen_write_o, d);
        end
        5: begin
          next_cycle();
          mem_size_i = a[1:0];
          reset_req_i = 1'b1;
          next_cycle();
          reset_req_i = 1'b0;
          @(negedge clk_sys);
          check("sys_reset_n_o", sys_reset_n_o, 1'b0);
          wait_reset_release(d[1:0]);
        end
        default: abort_run($sformatf("unknown opcode %h in record %0d", op, r));
      endcase
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: hdl/clk_enable_gen.sv
module clk_enable_gen (
  input  logic clk_sys,
  input  logic RESET,
  output logic cep_o,
  output logic cen_o,
  output logic cel_o,
  output logic cepix_o
);

  // eight system clocks make one cpu phase pair
  logic [2:0] div;

  always_ff @(posedge clk_sys, posedge RESET) begin
    if (RESET) begin
      div     <= '0;
      cep_o   <= 1'b0;
      cen_o   <= 1'b0;
      cel_o   <= 1'b0;
      cepix_o <= 1'b0;
    end else begin
      div     <= div + 3'd1;
      // strobes are compared on the old divider value
      cep_o   <= (div == 3'd0);
      cen_o   <= (div == 3'd4);
      cel_o   <= (div == 3'd7);
      // pixel rate is every fourth clock
      cepix_o <= (div[1:0] == 2'b00);
    end
  end

  // the cpu phases must never overlap
  a_cep_cen_excl: assert property (@(posedge clk_sys) disable iff (RESET)
    !(cep_o && cen_o))
    else $error("cep_o and cen_o high together");

endmodule

// File: hdl/download_packer.sv
module download_packer (
  input  logic        clk_sys,
  input  logic        RESET,
  input  logic        ioctl_wr_i,
  input  logic [24:0] ioctl_addr_i,
  input  logic [7:0]  ioctl_data_i,
  input  logic        dio_slot_i,
  output logic        ioctl_wait_o,
  output logic [15:0] dl_word_o,
  output logic [23:0] dl_word_addr_o,
  output logic        dl_we_o
);

  logic [7:0] hi_byte;
  logic       slot_q;
  logic       slot_fall;

  // ==================================================
  // byte to word packing
  // ==================================================

  always_ff @(posedge clk_sys, posedge RESET) begin
    if (RESET) begin
      hi_byte   <= '0;
      dl_word_o <= '0;
    end else if (ioctl_wr_i) begin
      if (!ioctl_addr_i[0]) begin
        hi_byte <= ioctl_data_i;
      end else begin
        // big endian with the even byte high
        dl_word_o <= {hi_byte, ioctl_data_i};
      end
    end
  end

  // host keeps the address still while it waits
  assign dl_word_addr_o = ioctl_addr_i[24:1];

  // ==================================================
  // wait flag tied to the memory slot
  // ==================================================

  assign slot_fall = slot_q && !dio_slot_i;

  always_ff @(posedge clk_sys, posedge RESET) begin
    if (RESET) begin
      slot_q       <= 1'b0;
      dl_we_o      <= 1'b0;
      ioctl_wait_o <= 1'b0;
    end else begin
      slot_q <= dio_slot_i;
      // a finished word stalls the host
      if (ioctl_wr_i && ioctl_addr_i[0]) begin
        ioctl_wait_o <= 1'b1;
      end
      // arm outside the slot so we is stable through the whole slot
      if (!dio_slot_i) begin
        dl_we_o <= ioctl_wait_o;
      end
      // the slot that carried the write has ended
      if (slot_fall && dl_we_o) begin
        ioctl_wait_o <= 1'b0;
      end
    end
  end

  a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
    ioctl_wait_o |-> !ioctl_wr_i)
    else $error("host byte strobe while ioctl_wait_o is high");

endmodule

// File: hdl/image_mapper.sv
module image_mapper (
  input  logic                     clk_sys,
  input  logic                     RESET,
  input  logic                     ioctl_download_i,
  input  logic [7:0]               ioctl_index_i,
  input  logic [23:0]              dl_word_addr_i,
  input  logic [1:0]               disk_eject_i,
  output mac_glue_pkg::sdram_addr_t dl_sdram_addr_o,
  output logic [1:0]               disk_inserted_o,
  output logic [1:0]               disk_double_o
);

  import mac_glue_pkg::*;

  logic [20:0] img_ofs;
  logic        old_down;
  logic        dl_end;
  logic [1:0]  drive_sel;
  logic [1:0]  dsk_ds;
  logic [1:0]  dsk_ss;

  // ==================================================
  // sdram placement
  // ==================================================

  always_comb begin
    case (ioctl_index_i)
      IDX_ROM: img_ofs = '0;
      IDX_INT: img_ofs = IMG_OFS_INT;
      // anything else lands in the external drive area
      default: img_ofs = IMG_OFS_EXT;
    endcase
  end

  always_comb begin
    dl_sdram_addr_o.dl.region = DL_REGION;
    dl_sdram_addr_o.dl.ofs    = img_ofs + dl_word_addr_i[20:0];
  end

  // ==================================================
  // disk sidedness at end of download
  // ==================================================

  assign dl_end    = old_down && !ioctl_download_i;
  assign drive_sel = {ioctl_index_i == IDX_EXT, ioctl_index_i == IDX_INT};

  always_ff @(posedge clk_sys, posedge RESET) begin
    if (RESET) begin
      old_down <= 1'b0;
      dsk_ds   <= '0;
      dsk_ss   <= '0;
    end else begin
      old_down <= ioctl_download_i;
      for (int i = 0; i < 2; i++) begin
        // address counts words, so a full image ends exactly here
        if (dl_end && drive_sel[i]) begin
          dsk_ds[i] <= (dl_word_addr_i == DISK_WORDS_DS);
          dsk_ss[i] <= (dl_word_addr_i == DISK_WORDS_SS);
        end
        // eject wins over a download ending in the same cycle
        if (disk_eject_i[i]) begin
          dsk_ds[i] <= 1'b0;
          dsk_ss[i] <= 1'b0;
        end
      end
    end
  end

  // odd sized images are not reported as inserted
  assign disk_double_o   = dsk_ds;
  assign disk_inserted_o = dsk_ds | dsk_ss;

endmodule

// File: hdl/mac_glue_pkg.sv
package mac_glue_pkg;

  // ==================================================
  // sdram word address, seen two ways
  // ==================================================

  // download view puts the region number above the image offset
  typedef struct packed {
    logic [3:0]  region;
    logic [20:0] ofs;
  } sdram_dl_view_t;

  // cpu view puts rom select above the 68k word address
  typedef struct packed {
    logic [2:0]  pad;
    logic        rom_sel;
    logic [20:0] word;
  } sdram_cpu_view_t;

  typedef union packed {
    sdram_dl_view_t  dl;
    sdram_cpu_view_t cpu;
  } sdram_addr_t;

  // ==================================================
  // image placement and disk sizes
  // ==================================================

  // floppy images sit right after the os rom
  localparam logic [20:0] IMG_OFS_INT = 21'h080000;
  localparam logic [20:0] IMG_OFS_EXT = 21'h100000;
  localparam logic [3:0]  DL_REGION   = 4'd1;

  // final word address of a complete image (819200 and 409600 bytes)
  localparam logic [23:0] DISK_WORDS_DS = 24'd409600;
  localparam logic [23:0] DISK_WORDS_SS = 24'd204800;

  localparam logic [7:0] IDX_ROM = 8'd0;
  localparam logic [7:0] IDX_INT = 8'd1;
  localparam logic [7:0] IDX_EXT = 8'd2;

  // 0 128KB, 1 512KB, 2 1MB, 3 4MB
  typedef logic [1:0] ram_size_t;

endpackage

// File: hdl/mac_mem_glue.sv
module mac_mem_glue #(
  parameter int RESET_BITS = 16
) (
  input  logic                    clk_sys,
  input  logic                    RESET,
  input  logic                    pll_locked_i,
  input  logic                    reset_req_i,
  input  mac_glue_pkg::ram_size_t mem_size_i,
  // host download
  input  logic                    ioctl_download_i,
  input  logic [7:0]              ioctl_index_i,
  input  logic                    ioctl_wr_i,
  input  logic [24:0]             ioctl_addr_i,
  input  logic [7:0]              ioctl_data_i,
  output logic                    ioctl_wait_o,
  input  logic                    dio_slot_i,
  // floppy state
  input  logic [1:0]              disk_eject_i,
  output logic [1:0]              disk_inserted_o,
  output logic [1:0]              disk_double_o,
  // cpu memory request
  input  logic [21:0]             mem_addr_i,
  input  logic [15:0]             mem_data_i,
  input  logic                    mem_uds_n_i,
  input  logic                    mem_lds_n_i,
  input  logic                    ram_we_n_i,
  input  logic                    ram_oe_n_i,
  input  logic                    rom_oe_n_i,
  // sdram port
  output logic [24:0]             sdram_addr_o,
  output logic [15:0]             sdram_din_o,
  output logic [1:0]              sdram_ds_o,
  output logic                    sdram_we_o,
  output logic                    sdram_oe_o,
  output logic                    screen_write_o,
  // system control
  output logic                    cep_o,
  output logic                    cen_o,
  output logic                    cel_o,
  output logic                    cepix_o,
  output logic                    sys_reset_n_o,
  output mac_glue_pkg::ram_size_t ram_size_o
);

  import mac_glue_pkg::*;

  logic [15:0] dl_word;
  logic [23:0] dl_word_addr;
  logic        dl_we;
  sdram_addr_t dl_sdram_addr;

  // ==================================================
  // clocking and reset
  // ==================================================

  clk_enable_gen u_clk_enable_gen (
    .clk_sys (clk_sys),
    .RESET   (RESET),
    .cep_o   (cep_o),
    .cen_o   (cen_o),
    .cel_o   (cel_o),
    .cepix_o (cepix_o)
  );

  reset_sequencer #(
    .RESET_BITS (RESET_BITS)
  ) u_reset_sequencer (
    .clk_sys       (clk_sys),
    .RESET         (RESET),
    .cen_i         (cen_o),
    .pll_locked_i  (pll_locked_i),
    .reset_req_i   (reset_req_i),
    .mem_size_i    (mem_size_i),
    .sys_reset_n_o (sys_reset_n_o),
    .ram_size_o    (ram_size_o)
  );

  // ==================================================
  // download path and sdram port
  // ==================================================

  download_packer u_download_packer (
    .clk_sys        (clk_sys),
    .RESET          (RESET),
    .ioctl_wr_i     (ioctl_wr_i),
    .ioctl_addr_i   (ioctl_addr_i),
    .ioctl_data_i   (ioctl_data_i),
    .dio_slot_i     (dio_slot_i),
    .ioctl_wait_o   (ioctl_wait_o),
    .dl_word_o      (dl_word),
    .dl_word_addr_o (dl_word_addr),
    .dl_we_o        (dl_we)
  );

  image_mapper u_image_mapper (
    .clk_sys          (clk_sys),
    .RESET            (RESET),
    .ioctl_download_i (ioctl_download_i),
    .ioctl_index_i    (ioctl_index_i),
    .dl_word_addr_i   (dl_word_addr),
    .disk_eject_i     (disk_eject_i),
    .dl_sdram_addr_o  (dl_sdram_addr),
    .disk_inserted_o  (disk_inserted_o),
    .disk_double_o    (disk_double_o)
  );

  sdram_port_mux u_sdram_port_mux (
    .ioctl_download_i (ioctl_download_i),
    .dio_slot_i       (dio_slot_i),
    .dl_sdram_addr_i  (dl_sdram_addr),
    .dl_word_i        (dl_word),
    .dl_we_i          (dl_we),
    .mem_addr_i       (mem_addr_i),
    .mem_data_i       (mem_data_i),
    .mem_uds_n_i      (mem_uds_n_i),
    .mem_lds_n_i      (mem_lds_n_i),
    .ram_we_n_i       (ram_we_n_i),
    .ram_oe_n_i       (ram_oe_n_i),
    .rom_oe_n_i       (rom_oe_n_i),
    .ram_size_i       (ram_size_o),
    .sdram_addr_o     (sdram_addr_o),
    .sdram_din_o      (sdram_din_o),
    .sdram_ds_o       (sdram_ds_o),
    .sdram_we_o       (sdram_we_o),
    .sdram_oe_o       (sdram_oe_o),
    .screen_write_o   (screen_write_o)
  );

endmodule

// File: hdl/reset_sequencer.sv
module reset_sequencer #(
  parameter int RESET_BITS = 16
) (
  input  logic                   clk_sys,
  input  logic                   RESET,
  input  logic                   cen_i,
  input  logic                   pll_locked_i,
  input  logic                   reset_req_i,
  input  mac_glue_pkg::ram_size_t mem_size_i,
  output logic                   sys_reset_n_o,
  output mac_glue_pkg::ram_size_t ram_size_o
);

  logic                  sync_reset;
  logic [3:0]            reset_pipe;
  logic [RESET_BITS-1:0] rst_cnt;
  logic                  rst_src;

  // release of the async reset walks out through the pipe
  always_ff @(posedge clk_sys, posedge RESET) begin
    if (RESET) begin
      sync_reset <= 1'b1;
      reset_pipe <= '1;
    end else begin
      {sync_reset, reset_pipe} <= {sync_reset, reset_pipe} << 1;
    end
  end

  // any of these holds the machine down
  assign rst_src = !pll_locked_i || reset_req_i || sync_reset;

  always_ff @(posedge clk_sys, posedge RESET) begin
    if (RESET) begin
      rst_cnt       <= '1;
      sys_reset_n_o <= 1'b0;
      ram_size_o    <= '0;
    end else if (rst_src) begin
      rst_cnt       <= '1;
      sys_reset_n_o <= 1'b0;
    end else if (|rst_cnt) begin
      if (cen_i) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      // menu size code starts at 512KB, so shift by one
      ram_size_o <= mem_size_i + 2'd1;
    end else begin
      sys_reset_n_o <= 1'b1;
    end
  end

  // losing pll lock must pull the system into reset on the next clock
  a_pll_holds_reset: assert property (@(posedge clk_sys) disable iff (RESET)
    !pll_locked_i |=> !sys_reset_n_o)
    else $error("sys_reset_n_o high after pll lock lost");

endmodule

// File: hdl/sdram_port_mux.sv
module sdram_port_mux (
  input  logic                     ioctl_download_i,
  input  logic                     dio_slot_i,
  input  mac_glue_pkg::sdram_addr_t dl_sdram_addr_i,
  input  logic [15:0]              dl_word_i,
  input  logic                     dl_we_i,
  input  logic [21:0]              mem_addr_i,
  input  logic [15:0]              mem_data_i,
  input  logic                     mem_uds_n_i,
  input  logic                     mem_lds_n_i,
  input  logic                     ram_we_n_i,
  input  logic                     ram_oe_n_i,
  input  logic                     rom_oe_n_i,
  input  mac_glue_pkg::ram_size_t   ram_size_i,
  output logic [24:0]              sdram_addr_o,
  output logic [15:0]              sdram_din_o,
  output logic [1:0]               sdram_ds_o,
  output logic                     sdram_we_o,
  output logic                     sdram_oe_o,
  output logic                     screen_write_o
);

  import mac_glue_pkg::*;

  logic        download_cycle;
  sdram_addr_t port_addr;

  assign download_cycle = ioctl_download_i && dio_slot_i;

  always_comb begin
    if (download_cycle) begin
      port_addr = dl_sdram_addr_i;
    end else begin
      // ram and rom map straight into the 68k word space
      port_addr.cpu.pad     = 3'b000;
      port_addr.cpu.rom_sel = !rom_oe_n_i;
      port_addr.cpu.word    = mem_addr_i[21:1];
    end
  end

  assign sdram_addr_o = port_addr;
  assign sdram_din_o  = download_cycle ? dl_word_i : mem_data_i;
  assign sdram_ds_o   = download_cycle ? 2'b11 : {!mem_uds_n_i, !mem_lds_n_i};
  assign sdram_we_o   = download_cycle ? dl_we_i : !ram_we_n_i;
  assign sdram_oe_o   = download_cycle ? 1'b0 : (!ram_oe_n_i || !rom_oe_n_i);

  // screen buffer sits near the top of ram, so its base moves with the size
  always_comb begin
    case (ram_size_i)
      2'd0:    screen_write_o = !ram_we_n_i && (&mem_addr_i[16:15]);
      2'd1:    screen_write_o = !ram_we_n_i && (&mem_addr_i[18:15]);
      2'd2:    screen_write_o = !ram_we_n_i && (&mem_addr_i[19:15]);
      default: screen_write_o = !ram_we_n_i && (&mem_addr_i[21:15]);
    endcase
  end

endmodule

// File: list.f
hdl/mac_glue_pkg.sv
hdl/clk_enable_gen.sv
hdl/reset_sequencer.sv
hdl/download_packer.sv
hdl/image_mapper.sv
hdl/sdram_port_mux.sv
hdl/mac_mem_glue.sv
bench/tb_mac_mem_glue.sv
